/* hdl/icache_pkg.sv */
package icache_pkg;

    // address width seen by fetch and memory bus
    parameter int xlen = 32;

    // byte offset inside one 64-bit line
    parameter int line_offset_bits = 3;

    // transaction tag width, tag 0 is reserved for "none"
    parameter int mem_tag_bits = 4;

    typedef logic [mem_tag_bits-1:0] mem_tag_t;

    // memory bus commands
    // store is decoded by the memory but the icache only loads
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_t;

endpackage

/* hdl/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
    import icache_pkg::*;

    bus_command_t    command;   // request from the cache side
    logic [xlen-1:0] addr;      // line aligned request address
    mem_tag_t        response;  // granted tag, same cycle as command
    logic [63:0]     data;      // return data
    mem_tag_t        tag;       // tag of the return, zero when idle

    modport cache (
        output command,
        output addr,
        input  response,
        input  data,
        input  tag
    );

    modport memory (
        input  command,
        input  addr,
        output response,
        output data,
        output tag
    );

endinterface

/* hdl/icache_array.sv */
`timescale 1ns/1ps

module icache_array #(
    parameter int  cache_lines = 32,
    localparam int index_bits  = $clog2(cache_lines),
    localparam int tag_bits    = 16 - icache_pkg::line_offset_bits - index_bits
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [index_bits-1:0] rd_index,
    input  logic [tag_bits-1:0]   rd_tag,
    input  logic                  wr_en,
    input  logic [index_bits-1:0] wr_index,
    input  logic [tag_bits-1:0]   wr_tag,
    input  logic [63:0]           wr_data,
    output logic [63:0]           rd_data,
    output logic                  rd_hit
);

    logic [63:0]            line_data [cache_lines];
    logic [tag_bits-1:0]    line_tag  [cache_lines];
    logic [cache_lines-1:0] line_valid;

    // combinational read, hit answered in the fetch cycle
    assign rd_data = line_data[rd_index];
    assign rd_hit  = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            line_data[wr_index] <= wr_data;
            line_tag[wr_index]  <= wr_tag;
        end
    end

    // valid bits are the only state cleared by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (wr_en) begin
            line_valid[wr_index] <= 1'b1;
        end
    end

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int  cache_lines = 32,
    localparam int index_bits  = $clog2(cache_lines),
    localparam int tag_bits    = 16 - icache_pkg::line_offset_bits - index_bits
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [icache_pkg::xlen-1:0] fetch_addr,
    input  logic                        rd_hit,
    input  logic [63:0]                 rd_data,
    input  logic                        pf_req,
    input  logic [icache_pkg::xlen-1:0] pf_addr,
    input  logic                        pf_fill,
    input  logic [icache_pkg::xlen-1:0] pf_fill_addr,
    mem_bus_if.cache                    bus,
    output logic [index_bits-1:0]       rd_index,
    output logic [tag_bits-1:0]         rd_tag,
    output logic                        wr_en,
    output logic [index_bits-1:0]       wr_index,
    output logic [tag_bits-1:0]         wr_tag,
    output logic [63:0]                 wr_data,
    output logic [63:0]                 fetch_data,
    output logic                        fetch_valid,
    output logic                        miss_pulse,
    output logic [icache_pkg::xlen-1:0] miss_addr,
    output logic                        pf_grant
);
    import icache_pkg::*;

    logic [tag_bits-1:0]            cur_tag;
    logic [index_bits-1:0]          cur_index;
    logic [tag_bits-1:0]            pf_tag;
    logic [index_bits-1:0]          pf_index;
    logic [tag_bits+index_bits-1:0] last_line;
    logic                           changed_addr;
    logic                           miss_outstanding;
    logic                           miss_next;
    logic                           demand_req;
    logic                           demand_accepted;
    logic                           demand_fill;
    mem_tag_t                       demand_tag;   // zero while nothing is in flight

    assign {cur_tag, cur_index} = fetch_addr[15:line_offset_bits];
    assign {pf_tag, pf_index}   = pf_fill_addr[15:line_offset_bits];

    assign rd_index    = cur_index;
    assign rd_tag      = cur_tag;
    assign fetch_valid = rd_hit;
    assign fetch_data  = rd_data;

    assign changed_addr    = {cur_tag, cur_index} != last_line;
    assign demand_req      = miss_outstanding && !changed_addr;
    assign demand_accepted = demand_req && (bus.response != '0);
    // a return for a dropped address is not ours any more
    assign demand_fill     = (demand_tag != '0) && (demand_tag == bus.tag) && !changed_addr;

    // new miss on address change, or line lost while the address is held
    assign miss_next = !rd_hit && !demand_accepted && !demand_fill &&
                       (changed_addr || (demand_tag == '0));

    assign miss_pulse = changed_addr && !rd_hit;   // next-line prefetch trigger
    assign miss_addr  = fetch_addr;

    // demand load has priority, prefetch takes the idle bus
    always_comb begin
        bus.command = bus_none;
        bus.addr    = pf_addr;
        pf_grant    = 1'b0;
        if (demand_req) begin
            bus.command = bus_load;
            bus.addr    = {fetch_addr[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}};
        end else if (pf_req) begin
            bus.command = bus_load;
            pf_grant    = bus.response != '0;
        end
    end

    // fill source, only one return per cycle so no collision
    always_comb begin
        wr_en   = pf_fill || demand_fill;
        wr_data = bus.data;
        if (pf_fill) begin
            wr_index = pf_index;
            wr_tag   = pf_tag;
        end else begin
            wr_index = cur_index;
            wr_tag   = cur_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_line        <= '1;   // forces a "change" on the first fetch
            miss_outstanding <= 1'b0;
            demand_tag       <= '0;
        end else begin
            last_line        <= {cur_tag, cur_index};
            miss_outstanding <= miss_next;
            if (demand_accepted) begin
                demand_tag <= bus.response;
            end else if (changed_addr || demand_fill) begin
                demand_tag <= '0;
            end
        end
    end

endmodule

/* hdl/prefetch_mshr.sv */
`timescale 1ns/1ps

module prefetch_mshr #(
    parameter int cache_lines = 32,
    parameter int mshr_depth  = 4
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        miss_pulse,
    input  logic [icache_pkg::xlen-1:0] miss_addr,
    input  logic                        pf_grant,
    input  icache_pkg::mem_tag_t        bus_response,
    input  icache_pkg::mem_tag_t        ret_tag,
    output logic                        pf_req,
    output logic [icache_pkg::xlen-1:0] pf_addr,
    output logic                        pf_fill,
    output logic [icache_pkg::xlen-1:0] pf_fill_addr
);
    import icache_pkg::*;

    localparam int ptr_bits = $clog2(mshr_depth);

    logic [xlen-1:0]       entry_addr [mshr_depth];
    mem_tag_t              entry_tag  [mshr_depth];
    logic [mshr_depth-1:0] entry_valid;
    logic [mshr_depth-1:0] entry_sent;
    logic [ptr_bits-1:0]   alloc_ptr;
    logic [ptr_bits-1:0]   send_ptr;
    logic [ptr_bits-1:0]   ans_ptr;
    logic [xlen-1:0]       next_line;
    logic                  alloc;

    assign next_line = {miss_addr[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}}
                       + xlen'(1 << line_offset_bits);

    assign alloc = miss_pulse && !entry_valid[alloc_ptr];   // full ring skips

    assign pf_req  = entry_valid[send_ptr] && !entry_sent[send_ptr];
    assign pf_addr = entry_addr[send_ptr];

    // returns come back in issue order, so only the oldest sent entry can match
    assign pf_fill = entry_valid[ans_ptr] && entry_sent[ans_ptr] &&
                     (ret_tag != '0) && (ret_tag == entry_tag[ans_ptr]);
    assign pf_fill_addr = entry_addr[ans_ptr];

    // alloc, send and answer always hit different slots
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_sent  <= '0;
            alloc_ptr   <= '0;
            send_ptr    <= '0;
            ans_ptr     <= '0;
        end else begin
            if (alloc) begin
                entry_valid[alloc_ptr] <= 1'b1;
                entry_sent[alloc_ptr]  <= 1'b0;
                alloc_ptr              <= alloc_ptr + 1'b1;
            end
            if (pf_grant) begin
                entry_sent[send_ptr] <= 1'b1;
                send_ptr             <= send_ptr + 1'b1;
            end
            if (pf_fill) begin
                entry_valid[ans_ptr] <= 1'b0;
                entry_sent[ans_ptr]  <= 1'b0;
                ans_ptr              <= ans_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_addr[alloc_ptr] <= next_line;
        end
        if (pf_grant) begin
            entry_tag[send_ptr] <= bus_response;   // tag to wait for
        end
    end

endmodule

/* hdl/tagged_memory.sv */
`timescale 1ns/1ps

module tagged_memory #(
    parameter int mem_latency = 6,
    parameter int mem_words   = 1024
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load_en,
    input  logic [icache_pkg::xlen-1:0] load_addr,
    input  logic [63:0]                 load_data,
    mem_bus_if.memory                   bus
);
    import icache_pkg::*;

    localparam int word_bits = $clog2(mem_words);

    logic [63:0]                   mem [mem_words];
    logic [(1<<mem_tag_bits)-1:1]  tag_busy;   // tag 0 never allocated
    mem_tag_t                      next_tag;
    mem_tag_t                      grant_tag;  // zero when refused or idle
    logic                          tag_free;
    mem_tag_t                      pipe_tag  [mem_latency];
    logic [word_bits-1:0]          pipe_word [mem_latency];
    mem_tag_t                      ret_tag;
    logic [word_bits-1:0]          ret_word;

    assign ret_tag  = pipe_tag[mem_latency-1];
    assign ret_word = pipe_word[mem_latency-1];

    // a tag returning this cycle can be handed out again right away
    assign tag_free = !tag_busy[next_tag] || (ret_tag == next_tag);

    always_comb begin
        grant_tag = '0;
        case (bus.command)
            bus_load: begin
                if (tag_free) begin
                    grant_tag = next_tag;
                end
            end
            bus_store: grant_tag = '0;   // no write data lane, refused
            default:   grant_tag = '0;
        endcase
    end

    assign bus.response = grant_tag;
    assign bus.tag      = ret_tag;
    assign bus.data     = mem[ret_word];

    always_ff @(posedge clock) begin
        if (reset) begin
            tag_busy <= '0;
            next_tag <= mem_tag_t'(1);
        end else begin
            if (ret_tag != '0) begin
                tag_busy[ret_tag] <= 1'b0;
            end
            if (grant_tag != '0) begin
                tag_busy[grant_tag] <= 1'b1;
                next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + 1'b1;   // skip 0
            end
        end
    end

    // latency line, tag and word index travel together
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_latency; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= grant_tag;
            for (int i = 1; i < mem_latency; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        pipe_word[0] <= bus.addr[line_offset_bits +: word_bits];
        for (int i = 1; i < mem_latency; i++) begin
            pipe_word[i] <= pipe_word[i-1];
        end
    end

    // program image port
    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr[line_offset_bits +: word_bits]] <= load_data;
        end
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int cache_lines = 32,
    parameter int mshr_depth  = 4,
    parameter int mem_latency = 6,
    parameter int mem_words   = 1024
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [icache_pkg::xlen-1:0] fetch_addr,
    input  logic                        load_en,
    input  logic [icache_pkg::xlen-1:0] load_addr,
    input  logic [63:0]                 load_data,
    output logic [63:0]                 fetch_data,
    output logic                        fetch_valid
);
    import icache_pkg::*;

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits   = 16 - line_offset_bits - index_bits;

    logic [index_bits-1:0] rd_index;
    logic [tag_bits-1:0]   rd_tag;
    logic [63:0]           rd_data;
    logic                  rd_hit;
    logic                  wr_en;
    logic [index_bits-1:0] wr_index;
    logic [tag_bits-1:0]   wr_tag;
    logic [63:0]           wr_data;
    logic                  pf_req;
    logic [xlen-1:0]       pf_addr;
    logic                  pf_grant;
    logic                  pf_fill;
    logic [xlen-1:0]       pf_fill_addr;
    logic                  miss_pulse;
    logic [xlen-1:0]       miss_addr;

    mem_bus_if mem_bus ();

    icache_array #(
        .cache_lines (cache_lines)
    ) u_array (
        .clock    (clock),
        .reset    (reset),
        .rd_index (rd_index),
        .rd_tag   (rd_tag),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit)
    );

    icache_ctrl #(
        .cache_lines (cache_lines)
    ) u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .rd_hit       (rd_hit),
        .rd_data      (rd_data),
        .pf_req       (pf_req),
        .pf_addr      (pf_addr),
        .pf_fill      (pf_fill),
        .pf_fill_addr (pf_fill_addr),
        .bus          (mem_bus.cache),
        .rd_index     (rd_index),
        .rd_tag       (rd_tag),
        .wr_en        (wr_en),
        .wr_index     (wr_index),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .miss_pulse   (miss_pulse),
        .miss_addr    (miss_addr),
        .pf_grant     (pf_grant)
    );

    prefetch_mshr #(
        .cache_lines (cache_lines),
        .mshr_depth  (mshr_depth)
    ) u_mshr (
        .clock        (clock),
        .reset        (reset),
        .miss_pulse   (miss_pulse),
        .miss_addr    (miss_addr),
        .pf_grant     (pf_grant),
        .bus_response (mem_bus.response),
        .ret_tag      (mem_bus.tag),
        .pf_req       (pf_req),
        .pf_addr      (pf_addr),
        .pf_fill      (pf_fill),
        .pf_fill_addr (pf_fill_addr)
    );

    tagged_memory #(
        .mem_latency (mem_latency),
        .mem_words   (mem_words)
    ) u_memory (
        .clock     (clock),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (mem_bus.memory)
    );

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
    localparam int mem_latency = 6;
    localparam int wait_limit  = 4 * mem_latency + 20;   // cycles per fetch

    logic        clock;
    logic        reset;
    logic [31:0] fetch_addr;
    logic        load_en;
    logic [31:0] load_addr;
    logic [63:0] load_data;
    logic [63:0] fetch_data;
    logic        fetch_valid;

    // records from the data file
    logic [31:0] l_addr [$];
    logic [63:0] l_data [$];
    int          f_id   [$];
    logic [31:0] f_addr [$];
    logic [63:0] f_exp  [$];
    int          f_hold [$];
    int          f_mode [$];   // 0 miss, 1 hit, 2 abandoned miss

    logic [63:0] image [logic [31:0]];   // words as loaded
    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int          cycle_limit;

    icache_top #(
        .mem_latency (mem_latency)
    ) i_icache_top (
        .clock       (clock),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run stopped, no progress after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic read_records();
        int    fd;
        int    code;
        string kind;
        string rest;
        int          id;
        logic [31:0] addr;
        logic [63:0] data;
        int          hold;
        int          mode;
        fd = $fopen("test/icache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/icache_input.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "L") begin
                code = $fscanf(fd, "%h %h", addr, data);
                l_addr.push_back(addr);
                l_data.push_back(data);
            end else if (kind == "F") begin
                code = $fscanf(fd, "%d %h %h %d %d", id, addr, data, hold, mode);
                f_id.push_back(id);
                f_addr.push_back(addr);
                f_exp.push_back(data);
                f_hold.push_back(hold);
                f_mode.push_back(mode);
            end else begin
                code = $fgets(rest, fd);   // comment line
            end
        end
        $fclose(fd);
    endtask

    task automatic load_image();
        for (int i = 0; i < l_addr.size(); i++) begin
            @(posedge clock);
            load_en   <= 1'b1;
            load_addr <= l_addr[i];
            load_data <= l_data[i];
            image[l_addr[i]] = l_data[i];
        end
        @(posedge clock);
        load_en <= 1'b0;
    endtask

    task automatic run_fetch(input int id, input logic [31:0] addr, input logic [63:0] exp_col,
                             input int hold, input int mode);
        logic        ok;
        int          waited;
        logic [63:0] expected;
        ok = 1'b1;
        expected = '0;
        if (image.exists(addr)) begin
            expected = image[addr];
        end else begin
            $display("test %0d: address %h was never loaded", id, addr);
            ok = 1'b0;
        end
        if (expected != exp_col) begin
            $display("test %0d: data column does not match the loaded image", id);
            ok = 1'b0;
        end
        @(posedge clock);
        fetch_addr <= addr;
        @(negedge clock);
        if (mode == 1) begin
            assert (fetch_valid) else begin
                $display("Error: fetch_valid = %h, expected %h (test %0d, hit at %h)",
                         fetch_valid, 1'b1, id, addr);
                ok = 1'b0;
            end
        end else begin
            assert (!fetch_valid) else begin
                $display("Error: fetch_valid = %h, expected %h (test %0d, cold %h)",
                         fetch_valid, 1'b0, id, addr);
                ok = 1'b0;
            end
        end
        if (mode == 2) begin
            // leave before the miss completes
            repeat (hold) begin
                @(negedge clock);
                assert (!fetch_valid) else begin
                    $display("Error: fetch_valid = %h, expected %h (test %0d, abandoned)",
                             fetch_valid, 1'b0, id);
                    ok = 1'b0;
                end
            end
        end else begin
            waited = 0;
            while (!fetch_valid && waited < wait_limit) begin
                @(negedge clock);
                waited++;
            end
            assert (fetch_valid) else begin
                $display("test %0d: fetch_valid never rose for address %h", id, addr);
                ok = 1'b0;
            end
            if (fetch_valid) begin
                assert (fetch_data == expected) else begin
                    $display("Error: fetch_data = %h, expected %h (test %0d)",
                             fetch_data, expected, id);
                    ok = 1'b0;
                end
            end
            repeat (hold) begin
                @(negedge clock);
                if (fetch_valid) begin
                    assert (fetch_data == expected) else begin
                        $display("Error: fetch_data = %h, expected %h (test %0d, hold)",
                                 fetch_data, expected, id);
                        ok = 1'b0;
                    end
                end
            end
        end
        if (ok) begin
            pass_count++;
            $display("test %0d addr %h: ok", id, addr);
        end else begin
            fail_count++;
            $display("test %0d addr %h: failed", id, addr);
        end
    endtask

    initial begin
        int hold_sum;
        clock       = 1'b0;
        reset       = 1'b1;
        fetch_addr  = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        cycle_limit = 0;
        hold_sum    = 0;
        read_records();
        foreach (f_hold[i]) begin
            hold_sum += f_hold[i];
        end
        cycle_limit = wait_limit * f_id.size() + l_addr.size() + hold_sum + 16;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        load_image();
        for (int i = 0; i < f_id.size(); i++) begin
            run_fetch(f_id[i], f_addr[i], f_exp[i], f_hold[i], f_mode[i]);
        end
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && f_id.size() > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* test/icache_input.txt */
# L addr data : preload one 64-bit word into memory
# F test_id addr expected_data hold mode : mode 0 miss, 1 hit, 2 abandoned miss
L 00000000 0000000000000000
L 00000008 0000000000000008
L 00000100 a1a1a1a100000100
L 00000108 a2a2a2a200000108
L 00000110 a3a3a3a300000110
L 00000200 b1b1b1b100000200
L 00000208 b2b2b2b200000208
L 00000300 d1d1d1d100000300
L 00000308 d2d2d2d200000308
L 00000400 c1c1c1c100000400
L 00000408 c2c2c2c200000408
L 00000500 e1e1e1e100000500
L 00000508 e2e2e2e200000508
# cold miss on A, hold long enough for the next-line prefetch
F 1 00000100 a1a1a1a100000100 12 0
# repeat of A hits
F 3 00000100 a1a1a1a100000100 1 1
# A+8 was prefetched
F 4 00000108 a2a2a2a200000108 1 1
# B shares the index of A
F 5 00000200 b1b1b1b100000200 2 0
F 5 00000100 a1a1a1a100000100 2 0
# address leaves before the miss completes
F 6 00000300 d1d1d1d100000300 2 2
F 6 00000400 c1c1c1c100000400 12 0
# late returns must not show up on C
F 6 00000400 c1c1c1c100000400 1 1
F 7 00000408 c2c2c2c200000408 1 1
F 8 00000500 e1e1e1e100000500 12 0
F 8 00000508 e2e2e2e200000508 1 1

/* project.f */
hdl/icache_pkg.sv
hdl/mem_bus_if.sv
hdl/icache_array.sv
hdl/icache_ctrl.sv
hdl/prefetch_mshr.sv
hdl/tagged_memory.sv
hdl/icache_top.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -f project.f -o icache_sim \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
